//--- dma_module.sv
// Sprite DMA, 512 cycles per page into the sprite data port; the CPU must stay idle while busy
`default_nettype none

module dma_module (
	input wire clk,
	input wire reset,

	// CPU write watched for the start command
	input wire [15:0] cpu_addr,
	input wire [7:0] cpu_data_in,
	input wire cpu_write_en,

	// Memory bus while busy
	output logic [15:0] dma_addr,
	input wire [7:0] dma_data_in,
	output logic [7:0] dma_data_out,
	output logic dma_write_en,
	output logic busy
);

	logic [7:0] page_q;
	logic [7:0] count_q;
	logic write_phase_q;
	logic start;
	logic last_byte;

	assign start = cpu_write_en && !busy && (cpu_addr == nes_mem_pkg::addr_dma);
	assign last_byte = (count_q == 8'(nes_mem_pkg::dma_length - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			page_q <= '0;
			count_q <= '0;
			write_phase_q <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			page_q <= cpu_data_in;
			count_q <= '0;
			write_phase_q <= 1'b0;
		end else if (busy) begin
			write_phase_q <= ~write_phase_q;
			if (write_phase_q) begin
				count_q <= count_q + 8'd1;
				if (last_byte) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Read phase fetches from the page, write phase pushes to the sprite port
	assign dma_addr = write_phase_q ? nes_mem_pkg::addr_spram_data : {page_q, count_q};
	assign dma_write_en = busy && write_phase_q;

	// Byte read in the previous cycle is on the bus now
	assign dma_data_out = dma_data_in;

	// Every write follows a read of the same transfer
	a_write_after_read: assert property (@(posedge clk) disable iff (reset)
		dma_write_en |-> busy && $past(busy) && !$past(write_phase_q));

	a_cpu_idle: assert property (@(posedge clk) disable iff (reset)
		busy |-> !cpu_write_en);

endmodule

`default_nettype wire

//--- dual_port_ram.sv
// Byte RAM, port A read/write and port B read-only, one-cycle reads, contents undefined until written
`default_nettype none

module dual_port_ram #(
	parameter int depth = 2048
) (
	input wire clk,

	// Read/write port
	input wire [$clog2(depth)-1:0] a_addr,
	input wire [7:0] a_data_in,
	input wire a_write_en,
	output logic [7:0] a_data_out,

	// Read-only port
	input wire [$clog2(depth)-1:0] b_addr,
	output logic [7:0] b_data_out
);

	logic [7:0] mem [depth];

	// Port A returns the old byte on a write cycle
	always_ff @(posedge clk) begin
		if (a_write_en) begin
			mem[a_addr] <= a_data_in;
		end
		a_data_out <= mem[a_addr];
	end

	always_ff @(posedge clk) begin
		b_data_out <= mem[b_addr];
	end

endmodule

`default_nettype wire

//--- joycon_ctrl.sv
// One controller port; the strobe is written at the first port's address, reads return bit 0
`default_nettype none

module joycon_ctrl #(
	parameter logic [15:0] port_addr = nes_mem_pkg::addr_joy1
) (
	input wire clk,
	input wire reset,
	input wire [15:0] cpu_addr,
	input wire cpu_write_en,
	input wire cpu_read_en,
	input wire [7:0] cpu_data_in,
	output logic [7:0] joycon_in,
	input wire [7:0] buttons
);

	logic strobe_q;
	logic [7:0] shift_q;
	logic strobe_write;
	logic port_read;

	// Both ports share one strobe address
	assign strobe_write = cpu_write_en && (cpu_addr == nes_mem_pkg::addr_joy1);
	assign port_read = cpu_read_en && (cpu_addr == port_addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_q <= 1'b0;
			shift_q <= '0;
		end else begin
			if (strobe_write) begin
				strobe_q <= cpu_data_in[0];
			end
			// Reload while strobed, otherwise shift on each read
			if (strobe_q) begin
				shift_q <= buttons;
			end else if (port_read) begin
				shift_q <= {1'b1, shift_q[7:1]};
			end
		end
	end

	assign joycon_in = {7'b0, shift_q[0]};

	// Ones fill in behind the button bits
	a_fill_ones: assert property (@(posedge clk) disable iff (reset)
		port_read && !strobe_q |=> shift_q[7]);

endmodule

`default_nettype wire

//--- mem_ctrl.sv
// Top of the CPU memory side; DMA takes the bus while busy and CPU accesses in that time are dropped
`default_nettype none

module mem_ctrl (
	input wire clk,
	input wire reset,

	// CPU bus
	input wire [15:0] cpu_addr,
	input wire [7:0] cpu_data_in,
	input wire cpu_write_en,
	input wire cpu_read_en,
	output logic [7:0] cpu_data_out,

	// PPU side
	output logic [7:0] ppu_ctrl1,
	output logic [7:0] ppu_ctrl2,
	input wire [7:0] ppu_status,
	output logic [15:0] ppu_scroll_addr,
	input wire [15:0] vram_ppu_addr,
	output logic [7:0] vram_ppu_data,
	input wire [7:0] spram_ppu_addr,
	output logic [7:0] spram_ppu_data,
	output logic [7:0] spram_cpu_addr,
	output logic ppu_status_read,

	// Button states, one bit per button
	input wire [7:0] joycon_1,
	input wire [7:0] joycon_2,

	// High while the sprite DMA owns the bus
	output logic busy
);

	logic [15:0] mem_addr;
	logic [7:0] mem_data_in;
	logic [7:0] mem_data_out;
	logic mem_write_en;
	logic mem_read_en;

	logic [15:0] dma_addr;
	logic [7:0] dma_data_out;
	logic dma_write_en;

	logic cpu_write_ok;
	logic cpu_read_ok;

	logic [7:0] joycon_1_in;
	logic [7:0] joycon_2_in;

	assign cpu_write_ok = cpu_write_en && !busy;
	assign cpu_read_ok = cpu_read_en && !busy;

	// Bus ownership, DMA reads on every cycle it does not write
	assign mem_addr = busy ? dma_addr : cpu_addr;
	assign mem_data_in = busy ? dma_data_out : cpu_data_in;
	assign mem_write_en = busy ? dma_write_en : cpu_write_en;
	assign mem_read_en = busy ? !dma_write_en : cpu_read_ok;

	assign cpu_data_out = mem_data_out;

	mem_decode mem_decode_inst (
		.clk(clk),
		.reset(reset),
		.mem_addr(mem_addr),
		.mem_data_in(mem_data_in),
		.mem_data_out(mem_data_out),
		.mem_write_en(mem_write_en),
		.mem_read_en(mem_read_en),
		.ppu_ctrl1(ppu_ctrl1),
		.ppu_ctrl2(ppu_ctrl2),
		.ppu_status(ppu_status),
		.ppu_scroll_addr(ppu_scroll_addr),
		.vram_ppu_addr(vram_ppu_addr),
		.vram_ppu_data(vram_ppu_data),
		.spram_ppu_addr(spram_ppu_addr),
		.spram_ppu_data(spram_ppu_data),
		.spram_cpu_addr(spram_cpu_addr),
		.ppu_status_read(ppu_status_read),
		.joycon_1_in(joycon_1_in),
		.joycon_2_in(joycon_2_in)
	);

	// Sees the raw CPU write so it can flag writes during a transfer
	dma_module dma_module_inst (
		.clk(clk),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_data_in(cpu_data_in),
		.cpu_write_en(cpu_write_en),
		.dma_addr(dma_addr),
		.dma_data_in(mem_data_out),
		.dma_data_out(dma_data_out),
		.dma_write_en(dma_write_en),
		.busy(busy)
	);

	joycon_ctrl #(.port_addr(nes_mem_pkg::addr_joy1)) joycon_ctrl_1 (
		.clk(clk),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_write_en(cpu_write_ok),
		.cpu_read_en(cpu_read_ok),
		.cpu_data_in(cpu_data_in),
		.joycon_in(joycon_1_in),
		.buttons(joycon_1)
	);

	joycon_ctrl #(.port_addr(nes_mem_pkg::addr_joy2)) joycon_ctrl_2 (
		.clk(clk),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_write_en(cpu_write_ok),
		.cpu_read_en(cpu_read_ok),
		.cpu_data_in(cpu_data_in),
		.joycon_in(joycon_2_in),
		.buttons(joycon_2)
	);

endmodule

`default_nettype wire

//--- mem_ctrl_tb.sv
// Self-checking testbench; only written RAM locations are read back and the CPU stays idle while busy
`default_nettype none

module mem_ctrl_tb;

	logic clk;
	logic reset;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_data_in;
	logic cpu_write_en;
	logic cpu_read_en;
	wire [7:0] cpu_data_out;
	wire [7:0] ppu_ctrl1;
	wire [7:0] ppu_ctrl2;
	logic [7:0] ppu_status;
	wire [15:0] ppu_scroll_addr;
	logic [15:0] vram_ppu_addr;
	wire [7:0] vram_ppu_data;
	logic [7:0] spram_ppu_addr;
	wire [7:0] spram_ppu_data;
	wire [7:0] spram_cpu_addr;
	wire ppu_status_read;
	logic [7:0] joycon_1;
	logic [7:0] joycon_2;
	wire busy;

	// Reference model state
	logic [7:0] m_wram [nes_mem_pkg::wram_depth];
	logic [7:0] m_vram [nes_mem_pkg::vram_depth];
	logic [7:0] m_spram [nes_mem_pkg::spram_depth];
	logic m_toggle;
	logic [15:0] m_scroll;
	logic [15:0] m_vram_addr;
	logic [7:0] m_spram_addr;
	logic m_strobe;
	logic [7:0] m_shift1;
	logic [7:0] m_shift2;

	// Pending comparisons
	logic [15:0] got_q [$];
	logic [15:0] exp_q [$];
	string what_q [$];
	logic [15:0] cmp_got;
	logic [15:0] cmp_exp;
	string cmp_what;
	int checks;
	int errors;
	logic status_pulse;

	mem_ctrl mem_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_data_in(cpu_data_in),
		.cpu_write_en(cpu_write_en),
		.cpu_read_en(cpu_read_en),
		.cpu_data_out(cpu_data_out),
		.ppu_ctrl1(ppu_ctrl1),
		.ppu_ctrl2(ppu_ctrl2),
		.ppu_status(ppu_status),
		.ppu_scroll_addr(ppu_scroll_addr),
		.vram_ppu_addr(vram_ppu_addr),
		.vram_ppu_data(vram_ppu_data),
		.spram_ppu_addr(spram_ppu_addr),
		.spram_ppu_data(spram_ppu_data),
		.spram_cpu_addr(spram_cpu_addr),
		.ppu_status_read(ppu_status_read),
		.joycon_1(joycon_1),
		.joycon_2(joycon_2),
		.busy(busy)
	);

	always #10 clk = ~clk;

	// Expected byte for a CPU read in the current model state
	function automatic logic [7:0] ref_read(input logic [15:0] addr);
		logic [7:0] result;
		if (addr < 16'h2000) begin
			result = m_wram[addr[10:0]];
		end else begin
			case (addr)
				nes_mem_pkg::addr_ppu_status: result = ppu_status;
				nes_mem_pkg::addr_spram_data: result = m_spram[m_spram_addr];
				nes_mem_pkg::addr_vram_data: result = m_vram[m_vram_addr[10:0]];
				nes_mem_pkg::addr_joy1: result = {7'b0, m_shift1[0]};
				nes_mem_pkg::addr_joy2: result = {7'b0, m_shift2[0]};
				default: result = 8'h00;
			endcase
		end
		return result;
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr < 16'h2000) begin
			m_wram[addr[10:0]] = data;
		end
		case (addr)
			nes_mem_pkg::addr_spram_addr: m_spram_addr = data;
			nes_mem_pkg::addr_spram_data: begin
				m_spram[m_spram_addr] = data;
				m_spram_addr++;
			end
			nes_mem_pkg::addr_ppu_scroll: begin
				if (m_toggle) m_scroll[7:0] = data;
				else m_scroll[15:8] = data;
				m_toggle = !m_toggle;
			end
			nes_mem_pkg::addr_vram_addr: begin
				if (m_toggle) m_vram_addr[7:0] = data;
				else m_vram_addr[15:8] = data;
				m_toggle = !m_toggle;
			end
			nes_mem_pkg::addr_vram_data: begin
				m_vram[m_vram_addr[10:0]] = data;
				m_vram_addr++;
			end
			// Strobe high keeps both ports loaded with the buttons
			nes_mem_pkg::addr_joy1: begin
				if (m_strobe || data[0]) begin
					m_shift1 = joycon_1;
					m_shift2 = joycon_2;
				end
				m_strobe = data[0];
			end
			default: ;
		endcase
	endtask

	// Side effects of a CPU read
	task automatic model_read(input logic [15:0] addr);
		case (addr)
			nes_mem_pkg::addr_ppu_status: m_toggle = 1'b0;
			nes_mem_pkg::addr_vram_data: m_vram_addr++;
			nes_mem_pkg::addr_joy1: if (!m_strobe) m_shift1 = {1'b1, m_shift1[7:1]};
			nes_mem_pkg::addr_joy2: if (!m_strobe) m_shift2 = {1'b1, m_shift2[7:1]};
			default: ;
		endcase
	endtask

	task automatic queue_check(input string what, input logic [15:0] got, input logic [15:0] expected);
		what_q.push_back(what);
		got_q.push_back(got);
		exp_q.push_back(expected);
	endtask

	task automatic settle();
		@(negedge clk);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_addr <= addr;
		cpu_data_in <= data;
		cpu_write_en <= 1'b1;
		@(posedge clk);
		cpu_write_en <= 1'b0;
		model_write(addr, data);
	endtask

	// Data is sampled mid-cycle after the strobe edge
	task automatic cpu_read(input logic [15:0] addr, input string what);
		logic [7:0] expected;
		@(posedge clk);
		cpu_addr <= addr;
		cpu_read_en <= 1'b1;
		@(posedge clk);
		cpu_read_en <= 1'b0;
		@(negedge clk);
		expected = ref_read(addr);
		status_pulse = ppu_status_read;
		queue_check(what, 16'(cpu_data_out), 16'(expected));
		model_read(addr);
	endtask

	task automatic vram_port_check(input logic [15:0] addr);
		@(posedge clk);
		vram_ppu_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		queue_check("vram ppu port", 16'(vram_ppu_data), 16'(m_vram[addr[10:0]]));
	endtask

	task automatic spram_port_check(input logic [7:0] addr);
		@(posedge clk);
		spram_ppu_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		queue_check("sprite ppu port", 16'(spram_ppu_data), 16'(m_spram[addr]));
	endtask

	// Compare process
	always @(posedge clk) begin
		while (got_q.size() > 0) begin
			cmp_got = got_q.pop_front();
			cmp_exp = exp_q.pop_front();
			cmp_what = what_q.pop_front();
			checks++;
			if (cmp_got !== cmp_exp) begin
				errors++;
				$display("FAIL t=%0t %s: got %h expected %h", $time, cmp_what, cmp_got, cmp_exp);
			end
		end
	end

	initial begin
		int i;
		int rise_wait;
		int high_cycles;
		logic [15:0] addrs [16];
		logic [15:0] base;
		logic [7:0] page;
		logic [7:0] start_sp;
		logic [7:0] ctrl_a;
		logic [7:0] ctrl_b;

		void'($urandom(32'hc46a30ab));
		clk = 1'b0;
		reset = 1'b1;
		cpu_addr = '0;
		cpu_data_in = '0;
		cpu_write_en = 1'b0;
		cpu_read_en = 1'b0;
		ppu_status = '0;
		vram_ppu_addr = '0;
		spram_ppu_addr = '0;
		joycon_1 = '0;
		joycon_2 = '0;
		checks = 0;
		errors = 0;
		m_toggle = 1'b0;
		m_scroll = '0;
		m_vram_addr = '0;
		m_spram_addr = '0;
		m_strobe = 1'b0;
		m_shift1 = '0;
		m_shift2 = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// Work RAM through mirrors
		for (i = 0; i < 16; i++) begin
			addrs[i] = 16'($urandom) & 16'h1fff;
			cpu_write(addrs[i], 8'($urandom));
		end
		for (i = 0; i < 16; i++) begin
			cpu_read(addrs[i] ^ {3'b000, 2'($urandom), 11'h000}, "wram mirror read");
		end

		// PPU registers and the shared toggle
		ctrl_a = 8'($urandom);
		ctrl_b = 8'($urandom);
		cpu_write(nes_mem_pkg::addr_ppu_ctrl1, ctrl_a);
		cpu_write(nes_mem_pkg::addr_ppu_ctrl2, ctrl_b);
		settle();
		queue_check("ppu_ctrl1", 16'(ppu_ctrl1), 16'(ctrl_a));
		queue_check("ppu_ctrl2", 16'(ppu_ctrl2), 16'(ctrl_b));
		cpu_write(nes_mem_pkg::addr_ppu_scroll, 8'($urandom));
		cpu_write(nes_mem_pkg::addr_ppu_scroll, 8'($urandom));
		settle();
		queue_check("scroll pair", ppu_scroll_addr, m_scroll);
		cpu_write(nes_mem_pkg::addr_ppu_scroll, 8'($urandom));
		@(posedge clk);
		ppu_status <= 8'($urandom);
		cpu_read(nes_mem_pkg::addr_ppu_status, "ppu_status read");
		queue_check("status read pulse", 16'(status_pulse), 16'h0001);
		settle();
		queue_check("status pulse width", 16'(ppu_status_read), 16'h0000);
		cpu_write(nes_mem_pkg::addr_ppu_scroll, 8'($urandom));
		settle();
		queue_check("scroll after status read", ppu_scroll_addr, m_scroll);

		// VRAM run written through the data port
		cpu_read(nes_mem_pkg::addr_ppu_status, "ppu_status read");
		base = 16'($urandom);
		cpu_write(nes_mem_pkg::addr_vram_addr, base[15:8]);
		cpu_write(nes_mem_pkg::addr_vram_addr, base[7:0]);
		for (i = 0; i < 8; i++) begin
			cpu_write(nes_mem_pkg::addr_vram_data, 8'($urandom));
		end
		for (i = 0; i < 8; i++) begin
			vram_port_check(base + 16'(i));
		end
		cpu_write(nes_mem_pkg::addr_vram_addr, base[15:8]);
		cpu_write(nes_mem_pkg::addr_vram_addr, base[7:0]);
		for (i = 0; i < 8; i++) begin
			cpu_read(nes_mem_pkg::addr_vram_data, "vram data port read");
		end

		// Sprite RAM through 2003 and 2004
		start_sp = 8'($urandom);
		cpu_write(nes_mem_pkg::addr_spram_addr, start_sp);
		for (i = 0; i < 8; i++) begin
			cpu_write(nes_mem_pkg::addr_spram_data, 8'($urandom));
			settle();
			queue_check("spram_cpu_addr", 16'(spram_cpu_addr), 16'(m_spram_addr));
		end
		for (i = 0; i < 8; i++) begin
			spram_port_check(start_sp + 8'(i));
		end

		// Sprite DMA from one work RAM page
		page = 8'($urandom) & 8'h1f;
		for (i = 0; i < nes_mem_pkg::dma_length; i++) begin
			cpu_write({page, 8'(i)}, 8'($urandom));
		end
		cpu_write(nes_mem_pkg::addr_dma, page);
		for (i = 0; i < nes_mem_pkg::dma_length; i++) begin
			base = {page, 8'(i)};
			model_write(nes_mem_pkg::addr_spram_data, m_wram[base[10:0]]);
		end
		rise_wait = 0;
		do begin
			@(negedge clk);
			rise_wait++;
		end while (busy !== 1'b1 && rise_wait < 600);
		if (busy !== 1'b1) begin
			errors++;
			$display("Timeout: busy did not rise within 600 cycles of the DMA start write");
		end else begin
			queue_check("busy rise delay", 16'(rise_wait), 16'd1);
			high_cycles = 0;
			do begin
				@(negedge clk);
				high_cycles++;
			end while (busy === 1'b1 && high_cycles < 600);
			if (busy === 1'b1) begin
				errors++;
				$display("Timeout: busy was still high 600 cycles after the DMA started");
			end else begin
				queue_check("busy length", 16'(high_cycles), 16'(nes_mem_pkg::dma_length * 2));
				queue_check("spram_cpu_addr after DMA", 16'(spram_cpu_addr), 16'(m_spram_addr));
				for (i = 0; i < nes_mem_pkg::dma_length; i++) begin
					spram_port_check(8'(i));
				end
			end
		end

		// Controllers, button bits first and ones after
		@(posedge clk);
		joycon_1 <= 8'($urandom);
		joycon_2 <= 8'($urandom);
		cpu_write(nes_mem_pkg::addr_joy1, 8'h01);
		cpu_write(nes_mem_pkg::addr_joy1, 8'h00);
		for (i = 0; i < 10; i++) begin
			cpu_read(nes_mem_pkg::addr_joy1, "controller 1 bit");
		end
		for (i = 0; i < 10; i++) begin
			cpu_read(nes_mem_pkg::addr_joy2, "controller 2 bit");
		end

		// Let the compare process drain
		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_decode.sv
// CPU bus decoder; read data follows the strobe by one cycle and holds, no PPU register mirrors
`default_nettype none

module mem_decode (
	input wire clk,
	input wire reset,

	// Shared memory bus
	input wire [15:0] mem_addr,
	input wire [7:0] mem_data_in,
	output logic [7:0] mem_data_out,
	input wire mem_write_en,
	input wire mem_read_en,

	// PPU side
	output logic [7:0] ppu_ctrl1,
	output logic [7:0] ppu_ctrl2,
	input wire [7:0] ppu_status,
	output logic [15:0] ppu_scroll_addr,
	input wire [15:0] vram_ppu_addr,
	output logic [7:0] vram_ppu_data,
	input wire [7:0] spram_ppu_addr,
	output logic [7:0] spram_ppu_data,
	output logic [7:0] spram_cpu_addr,
	output logic ppu_status_read,

	// Current controller bits
	input wire [7:0] joycon_1_in,
	input wire [7:0] joycon_2_in
);

	logic [$clog2(nes_mem_pkg::wram_depth)-1:0] wram_addr;
	logic [$clog2(nes_mem_pkg::vram_depth)-1:0] vram_cpu_idx;
	logic [$clog2(nes_mem_pkg::vram_depth)-1:0] vram_ppu_idx;
	logic [15:0] vram_addr;
	logic write_toggle;

	logic wram_sel;
	logic hit_ctrl1, hit_ctrl2, hit_status, hit_spram_addr, hit_spram_data;
	logic hit_scroll, hit_vram_addr, hit_vram_data, hit_joy1, hit_joy2;

	logic [7:0] wram_rd_data, vram_rd_data, spram_rd_data;

	logic rd_valid_q;
	logic rd_wram_q, rd_vram_q, rd_spram_q;
	logic [7:0] rd_reg_q;
	logic [7:0] read_mux;
	logic [7:0] data_hold_q;

	// Work RAM mirrors every 2 KB below the PPU window
	assign wram_sel = (mem_addr[15:13] == 3'b000);
	assign wram_addr = mem_addr[$clog2(nes_mem_pkg::wram_depth)-1:0];
	assign vram_cpu_idx = vram_addr[$clog2(nes_mem_pkg::vram_depth)-1:0];
	assign vram_ppu_idx = vram_ppu_addr[$clog2(nes_mem_pkg::vram_depth)-1:0];

	assign hit_ctrl1 = (mem_addr == nes_mem_pkg::addr_ppu_ctrl1);
	assign hit_ctrl2 = (mem_addr == nes_mem_pkg::addr_ppu_ctrl2);
	assign hit_status = (mem_addr == nes_mem_pkg::addr_ppu_status);
	assign hit_spram_addr = (mem_addr == nes_mem_pkg::addr_spram_addr);
	assign hit_spram_data = (mem_addr == nes_mem_pkg::addr_spram_data);
	assign hit_scroll = (mem_addr == nes_mem_pkg::addr_ppu_scroll);
	assign hit_vram_addr = (mem_addr == nes_mem_pkg::addr_vram_addr);
	assign hit_vram_data = (mem_addr == nes_mem_pkg::addr_vram_data);
	assign hit_joy1 = (mem_addr == nes_mem_pkg::addr_joy1);
	assign hit_joy2 = (mem_addr == nes_mem_pkg::addr_joy2);

	dual_port_ram #(.depth(nes_mem_pkg::wram_depth)) wram_inst (
		.clk(clk),
		.a_addr(wram_addr),
		.a_data_in(mem_data_in),
		.a_write_en(mem_write_en && wram_sel),
		.a_data_out(wram_rd_data),
		.b_addr(wram_addr),
		.b_data_out()
	);

	dual_port_ram #(.depth(nes_mem_pkg::vram_depth)) vram_inst (
		.clk(clk),
		.a_addr(vram_cpu_idx),
		.a_data_in(mem_data_in),
		.a_write_en(mem_write_en && hit_vram_data),
		.a_data_out(vram_rd_data),
		.b_addr(vram_ppu_idx),
		.b_data_out(vram_ppu_data)
	);

	dual_port_ram #(.depth(nes_mem_pkg::spram_depth)) spram_inst (
		.clk(clk),
		.a_addr(spram_cpu_addr),
		.a_data_in(mem_data_in),
		.a_write_en(mem_write_en && hit_spram_data),
		.a_data_out(spram_rd_data),
		.b_addr(spram_ppu_addr),
		.b_data_out(spram_ppu_data)
	);

	// PPU registers and address counters
	always_ff @(posedge clk) begin
		if (reset) begin
			ppu_ctrl1 <= '0;
			ppu_ctrl2 <= '0;
			ppu_scroll_addr <= '0;
			vram_addr <= '0;
			spram_cpu_addr <= '0;
			write_toggle <= 1'b0;
			ppu_status_read <= 1'b0;
		end else begin
			ppu_status_read <= mem_read_en && hit_status;
			if (mem_write_en) begin
				if (hit_ctrl1) begin
					ppu_ctrl1 <= mem_data_in;
				end
				if (hit_ctrl2) begin
					ppu_ctrl2 <= mem_data_in;
				end
				if (hit_spram_addr) begin
					spram_cpu_addr <= mem_data_in;
				end
				if (hit_spram_data) begin
					spram_cpu_addr <= spram_cpu_addr + 8'd1;
				end
				// First write lands in the high byte
				if (hit_scroll) begin
					if (write_toggle) begin
						ppu_scroll_addr[7:0] <= mem_data_in;
					end else begin
						ppu_scroll_addr[15:8] <= mem_data_in;
					end
					write_toggle <= ~write_toggle;
				end
				if (hit_vram_addr) begin
					if (write_toggle) begin
						vram_addr[7:0] <= mem_data_in;
					end else begin
						vram_addr[15:8] <= mem_data_in;
					end
					write_toggle <= ~write_toggle;
				end
			end
			// Data port steps after every access
			if (hit_vram_data && (mem_write_en || mem_read_en)) begin
				vram_addr <= vram_addr + 16'd1;
			end
			if (mem_read_en && hit_status) begin
				write_toggle <= 1'b0;
			end
		end
	end

	// Remember what was read, RAM bytes arrive a cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
			rd_wram_q <= 1'b0;
			rd_vram_q <= 1'b0;
			rd_spram_q <= 1'b0;
			rd_reg_q <= '0;
		end else begin
			rd_valid_q <= mem_read_en;
			if (mem_read_en) begin
				rd_wram_q <= wram_sel;
				rd_vram_q <= hit_vram_data;
				rd_spram_q <= hit_spram_data;
				if (hit_status) begin
					rd_reg_q <= ppu_status;
				end else if (hit_joy1) begin
					rd_reg_q <= joycon_1_in;
				end else if (hit_joy2) begin
					rd_reg_q <= joycon_2_in;
				end else begin
					rd_reg_q <= '0;
				end
			end
		end
	end

	always_comb begin
		if (rd_wram_q) begin
			read_mux = wram_rd_data;
		end else if (rd_vram_q) begin
			read_mux = vram_rd_data;
		end else if (rd_spram_q) begin
			read_mux = spram_rd_data;
		end else begin
			read_mux = rd_reg_q;
		end
	end

	// Live for one cycle after the strobe, then held
	assign mem_data_out = rd_valid_q ? read_mux : data_hold_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			data_hold_q <= '0;
		end else begin
			data_hold_q <= mem_data_out;
		end
	end

	// CPU and DMA strobes never collide on the shared bus
	a_no_rw_overlap: assert property (@(posedge clk) disable iff (reset)
		!(mem_write_en && mem_read_en));

endmodule

`default_nettype wire

//--- nes_mem_pkg.sv
// Register map and sizes for the CPU side; only exact register addresses decode, no PPU mirrors
`default_nettype none

package nes_mem_pkg;

	// Memory sizes in bytes
	localparam int wram_depth = 2048;
	localparam int vram_depth = 2048;
	localparam int spram_depth = 256;

	// PPU register window
	localparam logic [15:0] addr_ppu_ctrl1 = 16'h2000;
	localparam logic [15:0] addr_ppu_ctrl2 = 16'h2001;
	localparam logic [15:0] addr_ppu_status = 16'h2002;
	localparam logic [15:0] addr_spram_addr = 16'h2003;
	localparam logic [15:0] addr_spram_data = 16'h2004;
	localparam logic [15:0] addr_ppu_scroll = 16'h2005;
	localparam logic [15:0] addr_vram_addr = 16'h2006;
	localparam logic [15:0] addr_vram_data = 16'h2007;

	// Sprite DMA trigger
	localparam logic [15:0] addr_dma = 16'h4014;

	// Controller ports, strobe is written through the first one
	localparam logic [15:0] addr_joy1 = 16'h4016;
	localparam logic [15:0] addr_joy2 = 16'h4017;

	// One full page per transfer
	localparam int dma_length = 256;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_ctrl testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module mem_ctrl_tb \
	-Mdir obj_dir -o sim_mem_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mem_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "All tests passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sources.f
nes_mem_pkg.sv
dual_port_ram.sv
mem_decode.sv
dma_module.sv
joycon_ctrl.sv
mem_ctrl.sv
mem_ctrl_tb.sv
